// ==== rf_pkg.sv ====
// Register file geometry, queue pointer sizes and the shared address, data and pointer types
`default_nettype none

package rf_pkg;

    // ------------------------------
    // Register file geometry
    // ------------------------------

    // Number of entries held by the two-port array
    localparam int RF_DEPTH = 256;

    // Address width needed to reach every entry
    localparam int RF_ADDR_W = 8;

    // Width of one stored entry
    localparam int RF_DATA_W = 10;

    // ------------------------------
    // Queue pointers and crossing
    // ------------------------------

    // Queue pointers carry one wrap bit above the entry address
    localparam int PTR_W = RF_ADDR_W + 1;

    // Flip-flop stages used by every clock domain synchronizer
    localparam int SYNC_STAGES = 2;

    // One entry address into the array
    typedef logic [RF_ADDR_W-1:0] rf_addr_t;

    // One stored entry
    typedef logic [RF_DATA_W-1:0] rf_data_t;

    // Binary or Gray queue pointer, wrap bit in the top position
    typedef logic [PTR_W-1:0] fifo_ptr_t;

endpackage

`default_nettype wire

// ==== reset_sync.sv ====
// Reset synchronizer for one clock domain with a scan style bypass
`timescale 1ns/1ps
`default_nettype none

module reset_sync #(
    // Number of flops in the release chain, at least two
    parameter int STAGES = 2
) (
     input  logic clk
    ,input  logic reset
    ,input  logic rst_bypass_en
    ,output logic reset_out
);

    // ------------------------------
    // Release chain
    // ------------------------------

    // Chain of flops that fills with ones during reset and drains to zero afterwards
    logic [STAGES-1:0] sync_q;

    // Internal reset as seen by the local domain before the bypass mux
    logic              reset_local;

    // The whole chain is loaded while the external reset is high, so the
    // release starts from a known state no matter how long reset lasted
    always_ff @(posedge clk) begin
        if (reset) begin
            sync_q <= '1;
        end else begin
            sync_q <= {sync_q[STAGES-2:0], 1'b0};
        end
    end

    // Assertion follows the external reset at once, release waits for the
    // zero to ripple through all stages of the local clock
    assign reset_local = reset | sync_q[STAGES-1];

    // Under bypass the local domain sees the external reset directly
    assign reset_out = rst_bypass_en ? reset : reset_local;

endmodule

`default_nettype wire

// ==== rf_array_2p.sv ====
// Behavioural two-clock register file array used in place of the memory macro
`timescale 1ns/1ps
`default_nettype none

module rf_array_2p import rf_pkg::*; (
     input  logic     wclk
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    ,input  logic     rclk
    ,input  logic     re
    ,input  rf_addr_t raddr

    ,input  logic     ip_reset
    ,output rf_data_t data_out
);

    // ------------------------------
    // Storage
    // ------------------------------

    // Entry storage with one word per queue slot
    rf_data_t mem [RF_DEPTH];

    // Write port lives entirely in the write clock domain
    always_ff @(posedge wclk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Read data is registered and appears one cycle after the read enable
    // The output register is cleared by the read domain reset so the
    // consumer never sees stale data right after reset
    // A read of an entry written in the same instant gives no defined value
    // and the queue controllers never issue one
    always_ff @(posedge rclk) begin
        if (ip_reset) begin
            data_out <= '0;
        end else if (re) begin
            data_out <= mem[raddr];
        end
    end

endmodule

`default_nettype wire

// ==== rf_256x10.sv ====
// Register file wrapper around the 256 by 10 two-port array with read domain reset sync
`timescale 1ns/1ps
`default_nettype none

module rf_256x10 import rf_pkg::*; (
     input  logic     wclk
    ,input  logic     wclk_reset
    ,input  logic     we
    ,input  rf_addr_t waddr
    ,input  rf_data_t wdata

    ,input  logic     rclk
    ,input  logic     rclk_reset
    ,input  logic     re
    ,input  rf_addr_t raddr

    ,input  logic     ip_reset
    ,input  logic     rst_bypass_en

    ,output rf_data_t rdata
);

    // Array reset after crossing into the read clock domain
    logic ip_reset_sync;

    // The output register of the array sits on rclk, so its reset is
    // brought into that domain first
    reset_sync #(
        .STAGES        (SYNC_STAGES)
    ) u_ip_reset_sync (
         .clk           (rclk)
        ,.reset         (ip_reset)
        ,.rst_bypass_en (rst_bypass_en)
        ,.reset_out     (ip_reset_sync)
    );

    // ------------------------------
    // Array
    // ------------------------------

    rf_array_2p u_rf (
         .wclk     (wclk)
        ,.we       (we)
        ,.waddr    (waddr)
        ,.wdata    (wdata)
        ,.rclk     (rclk)
        ,.re       (re)
        ,.raddr    (raddr)
        ,.ip_reset (ip_reset_sync)
        ,.data_out (rdata)
    );

    // ------------------------------
    // Usage checks
    // ------------------------------

    // Write enable must be known once the write domain is out of reset
    a_we_known: assert property (@(posedge wclk) disable iff (wclk_reset)
        !$isunknown(we));

    // Read enable must be known once the read domain is out of reset
    a_re_known: assert property (@(posedge rclk) disable iff (rclk_reset)
        !$isunknown(re));

    // An enabled access must carry a real address, otherwise the macro corrupts entries
    a_waddr_known: assert property (@(posedge wclk) disable iff (wclk_reset)
        we |-> !$isunknown(waddr));

    a_raddr_known: assert property (@(posedge rclk) disable iff (rclk_reset)
        re |-> !$isunknown(raddr));

endmodule

`default_nettype wire

// ==== fifo_wr_ctrl.sv ====
// Write side queue controller with write pointers, full flag and read pointer synchronizer
`timescale 1ns/1ps
`default_nettype none

module fifo_wr_ctrl import rf_pkg::*; (
     input  logic      wclk
    ,input  logic      wclk_reset

    ,input  logic      push
    ,input  rf_data_t  push_data

    ,input  fifo_ptr_t rptr_gray
    ,output fifo_ptr_t wptr_gray

    ,output logic      full

    ,output logic      we
    ,output rf_addr_t  waddr
    ,output rf_data_t  wdata
);

    // Binary write pointer whose low bits address the array
    fifo_ptr_t wbin;

    // Pointer values for the coming cycle
    fifo_ptr_t wbin_next;
    fifo_ptr_t wgray_next;

    // Read pointer as it arrives through the synchronizer chain
    fifo_ptr_t [SYNC_STAGES-1:0] rq_sync;
    fifo_ptr_t                   rptr_gray_sync;

    logic full_next;

    // ------------------------------
    // Write strobe and pointer step
    // ------------------------------

    // A push is only taken when there is room
    assign we    = push & ~full;
    assign waddr = wbin[RF_ADDR_W-1:0];
    assign wdata = push_data;

    // Pointer moves by one for each accepted push
    assign wbin_next  = wbin + fifo_ptr_t'(we);
    assign wgray_next = (wbin_next >> 1) ^ wbin_next;

    // Queue is full when the write pointer has lapped the read pointer once.
    // In Gray code that means the top two bits differ and the rest match
    assign rptr_gray_sync = rq_sync[SYNC_STAGES-1];
    assign full_next      = (wgray_next == {~rptr_gray_sync[PTR_W-1:PTR_W-2],
                                             rptr_gray_sync[PTR_W-3:0]});

    always_ff @(posedge wclk) begin
        if (wclk_reset) begin
            wbin      <= '0;
            wptr_gray <= '0;
            full      <= 1'b0;
        end else begin
            wbin      <= wbin_next;
            wptr_gray <= wgray_next;
            full      <= full_next;
        end
    end

    // ------------------------------
    // Read pointer synchronizer
    // ------------------------------

    // Only one bit of the Gray pointer changes per step, so each stage
    // samples either the old or the new value and never a mix
    always_ff @(posedge wclk) begin
        if (wclk_reset) begin
            rq_sync <= '0;
        end else begin
            rq_sync[0] <= rptr_gray;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                rq_sync[i] <= rq_sync[i-1];
            end
        end
    end

    // A moving read pointer only makes room, so full can only rise after an accepted write
    a_full_after_write: assert property (@(posedge wclk) disable iff (wclk_reset)
        $rose(full) |-> $past(we));

endmodule

`default_nettype wire

// ==== fifo_rd_ctrl.sv ====
// Read side queue controller with read pointers, empty flag, read strobe and write pointer sync
`timescale 1ns/1ps
`default_nettype none

module fifo_rd_ctrl import rf_pkg::*; (
     input  logic      rclk
    ,input  logic      rclk_reset

    ,input  logic      pop

    ,input  fifo_ptr_t wptr_gray
    ,output fifo_ptr_t rptr_gray

    ,output logic      empty

    ,output logic      re
    ,output rf_addr_t  raddr

    ,output logic      pop_valid
);

    // Binary read pointer whose low bits address the array
    fifo_ptr_t rbin;

    // Pointer values for the coming cycle
    fifo_ptr_t rbin_next;
    fifo_ptr_t rgray_next;

    // Write pointer as it arrives through the synchronizer chain
    fifo_ptr_t [SYNC_STAGES-1:0] wq_sync;
    fifo_ptr_t                   wptr_gray_sync;

    logic empty_next;

    // ------------------------------
    // Read strobe and pointer step
    // ------------------------------

    // A pop is only taken when an entry is present
    assign re    = pop & ~empty;
    assign raddr = rbin[RF_ADDR_W-1:0];

    // Pointer moves by one for each accepted pop
    assign rbin_next  = rbin + fifo_ptr_t'(re);
    assign rgray_next = (rbin_next >> 1) ^ rbin_next;

    // Empty when the read pointer catches up with the synchronized write pointer.
    // The write pointer seen here is a few cycles old, so empty can only
    // be pessimistic, never late
    assign wptr_gray_sync = wq_sync[SYNC_STAGES-1];
    assign empty_next     = (rgray_next == wptr_gray_sync);

    always_ff @(posedge rclk) begin
        if (rclk_reset) begin
            rbin      <= '0;
            rptr_gray <= '0;
            empty     <= 1'b1;
        end else begin
            rbin      <= rbin_next;
            rptr_gray <= rgray_next;
            empty     <= empty_next;
        end
    end

    // ------------------------------
    // Read data qualifier
    // ------------------------------

    // The array returns data one rclk edge after the strobe,
    // so the valid flag is the accepted pop delayed by one cycle
    always_ff @(posedge rclk) begin
        if (rclk_reset) begin
            pop_valid <= 1'b0;
        end else begin
            pop_valid <= re;
        end
    end

    // ------------------------------
    // Write pointer synchronizer
    // ------------------------------

    // Same two flop Gray crossing as on the write side
    always_ff @(posedge rclk) begin
        if (rclk_reset) begin
            wq_sync <= '0;
        end else begin
            wq_sync[0] <= wptr_gray;
            for (int i = 1; i < SYNC_STAGES; i++) begin
                wq_sync[i] <= wq_sync[i-1];
            end
        end
    end

    // A moving write pointer only adds entries, so empty can only rise after an accepted read
    a_empty_after_read: assert property (@(posedge rclk) disable iff (rclk_reset)
        $rose(empty) |-> $past(re));

endmodule

`default_nettype wire

// ==== cdc_fifo.sv ====
// Dual clock queue top level joining reset synchronizers, controllers and register file
`timescale 1ns/1ps
`default_nettype none

module cdc_fifo import rf_pkg::*; (
     input  logic     wclk
    ,input  logic     rclk
    ,input  logic     reset
    ,input  logic     rst_bypass_en

    ,input  logic     push
    ,input  rf_data_t push_data
    ,output logic     full

    ,input  logic     pop
    ,output logic     empty
    ,output rf_data_t pop_data
    ,output logic     pop_valid
);

    // Per domain copies of the external reset
    logic      wclk_reset;
    logic      rclk_reset;

    // Write port of the register file
    logic      we;
    rf_addr_t  waddr;
    rf_data_t  wdata;

    // Read port of the register file
    logic      re;
    rf_addr_t  raddr;

    // Gray pointers exchanged across the two domains
    fifo_ptr_t wptr_gray;
    fifo_ptr_t rptr_gray;

    // ------------------------------
    // Resets
    // ------------------------------

    reset_sync #(
        .STAGES        (SYNC_STAGES)
    ) u_wclk_reset_sync (
         .clk           (wclk)
        ,.reset         (reset)
        ,.rst_bypass_en (rst_bypass_en)
        ,.reset_out     (wclk_reset)
    );

    reset_sync #(
        .STAGES        (SYNC_STAGES)
    ) u_rclk_reset_sync (
         .clk           (rclk)
        ,.reset         (reset)
        ,.rst_bypass_en (rst_bypass_en)
        ,.reset_out     (rclk_reset)
    );

    // ------------------------------
    // Controllers
    // ------------------------------

    fifo_wr_ctrl u_wr_ctrl (
         .wclk       (wclk)
        ,.wclk_reset (wclk_reset)
        ,.push       (push)
        ,.push_data  (push_data)
        ,.rptr_gray  (rptr_gray)
        ,.wptr_gray  (wptr_gray)
        ,.full       (full)
        ,.we         (we)
        ,.waddr      (waddr)
        ,.wdata      (wdata)
    );

    fifo_rd_ctrl u_rd_ctrl (
         .rclk       (rclk)
        ,.rclk_reset (rclk_reset)
        ,.pop        (pop)
        ,.wptr_gray  (wptr_gray)
        ,.rptr_gray  (rptr_gray)
        ,.empty      (empty)
        ,.re         (re)
        ,.raddr      (raddr)
        ,.pop_valid  (pop_valid)
    );

    // ------------------------------
    // Storage
    // ------------------------------

    // The wrapper brings the raw reset into the read domain by itself
    rf_256x10 u_rf_256x10 (
         .wclk          (wclk)
        ,.wclk_reset    (wclk_reset)
        ,.we            (we)
        ,.waddr         (waddr)
        ,.wdata         (wdata)
        ,.rclk          (rclk)
        ,.rclk_reset    (rclk_reset)
        ,.re            (re)
        ,.raddr         (raddr)
        ,.ip_reset      (reset)
        ,.rst_bypass_en (rst_bypass_en)
        ,.rdata         (pop_data)
    );

endmodule

`default_nettype wire

// ==== tb_cdc_fifo.sv ====
// Testbench for the dual clock queue with clocks, LFSR, stimulus table, reference queue and checks
`timescale 1ns/1ps
`default_nettype none

module tb_cdc_fifo import rf_pkg::*; ();

    // One phase of the test run
    typedef struct {
        int pushes;
        int pops;
        bit concurrent;
        bit over_full;
        bit bypass;
    } row_t;

    localparam int ROW_COUNT = 5;

    // Extra pushes attempted while the queue reports full
    localparam int OVERRUN_PUSHES = 8;

    // DUT inputs start at known values before the first clock edge
    logic     wclk          = 1'b0;
    logic     rclk          = 1'b0;
    logic     reset         = 1'b1;
    logic     rst_bypass_en = 1'b0;
    logic     push          = 1'b0;
    rf_data_t push_data     = '0;
    logic     pop           = 1'b0;

    logic     full;
    logic     empty;
    rf_data_t pop_data;
    logic     pop_valid;

    row_t     rows [ROW_COUNT];
    rf_data_t ref_q [$];
    logic [9:0] lfsr_state = 10'd71;

    // Accepted pop as seen at the falling edge, and the same one edge later
    logic     pop_taken      = 1'b0;
    logic     valid_expected = 1'b0;

    int       cycle_count  = 0;
    int       cycle_limit  = 0;

    // ------------------------------
    // Clocks and DUT
    // ------------------------------

    always #4 wclk = ~wclk;

    // Same period as wclk but shifted by 3 ns so no edges line up
    always begin
        #3;
        forever #4 rclk = ~rclk;
    end

    cdc_fifo u_cdc_fifo (
         .wclk          (wclk)
        ,.rclk          (rclk)
        ,.reset         (reset)
        ,.rst_bypass_en (rst_bypass_en)
        ,.push          (push)
        ,.push_data     (push_data)
        ,.full          (full)
        ,.pop           (pop)
        ,.empty         (empty)
        ,.pop_data      (pop_data)
        ,.pop_valid     (pop_valid)
    );

    // ------------------------------
    // Reporting and checks
    // ------------------------------

    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "simulation stopped on the first error");
    endtask

    task automatic check_data(input string name, input rf_data_t expected, input rf_data_t actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected 0x%h actual 0x%h",
                                        $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            stop_with_failure($sformatf("CHECK FAILED at %0t: %s expected %b actual %b",
                                        $time, name, expected, actual));
        end
    endtask

    // Taps at bits 10 and 7 give a maximal length sequence
    function automatic logic [9:0] lfsr_next(input logic [9:0] state);
        return {state[8:0], state[9] ^ state[6]};
    endfunction

    // One LFSR step per bit with the bits filling from the low end
    task automatic take_random_bits(input int count, output rf_data_t bits);
        bits = '0;
        for (int i = 0; i < count; i++) begin
            bits       = {bits[RF_DATA_W-2:0], lfsr_state[9]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    // The cycle limit comes from the table and stops a run that never finishes
    always @(posedge wclk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
            stop_with_failure($sformatf("Timeout after %0d wclk cycles", cycle_count));
        end
    end

    // ------------------------------
    // Read data monitor
    // ------------------------------

    // The DUT must flag valid data exactly one rclk cycle after an accepted pop
    always @(posedge rclk) begin
        valid_expected <= pop_taken;
    end

    always @(negedge rclk) begin
        check_flag("pop_valid", valid_expected, pop_valid);
        if (pop_valid) begin
            if (ref_q.size() == 0) begin
                stop_with_failure("The DUT returned data that was never pushed");
            end else begin
                check_data("pop_data", ref_q.pop_front(), pop_data);
            end
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------

    task automatic apply_reset(input bit bypass);
        @(negedge wclk);
        reset         = 1'b1;
        rst_bypass_en = bypass;
        repeat (8) @(negedge wclk);
        reset = 1'b0;
        // Release takes SYNC_STAGES edges of each clock
        repeat (SYNC_STAGES + 2) @(negedge wclk);
    endtask

    task automatic expect_idle_flags();
        check_flag("full", 1'b0, full);
        @(negedge rclk);
        check_flag("empty", 1'b1, empty);
        check_flag("pop_valid", 1'b0, pop_valid);
        check_data("pop_data", '0, pop_data);
    endtask

    // Pops on an empty queue must be ignored for the whole window
    task automatic probe_empty_pop();
        repeat (10) begin
            @(negedge rclk);
            check_flag("empty", 1'b1, empty);
            pop       = 1'b1;
            pop_taken = pop & ~empty;
        end
        @(negedge rclk);
        pop       = 1'b0;
        pop_taken = 1'b0;
    endtask

    // A push counts as accepted when full is low at the driving edge,
    // since full only moves on the rising edge that follows
    task automatic push_items(input int count, input bit random_rate);
        int       accepted;
        rf_data_t bits;
        rf_data_t value;
        accepted = 0;
        while (accepted < count) begin
            @(negedge wclk);
            bits = '1;
            if (random_rate) begin
                take_random_bits(2, bits);
            end
            if (bits[1:0] != 2'b00) begin
                take_random_bits(RF_DATA_W, value);
                push      = 1'b1;
                push_data = value;
                if (!full) begin
                    ref_q.push_back(value);
                    accepted++;
                end
            end else begin
                push = 1'b0;
            end
        end
        @(negedge wclk);
        push = 1'b0;
    endtask

    // None of the pushes against a full queue may be stored
    task automatic overrun_pushes(input int count);
        rf_data_t value;
        repeat (count) begin
            @(negedge wclk);
            check_flag("full", 1'b1, full);
            take_random_bits(RF_DATA_W, value);
            push      = 1'b1;
            push_data = value;
        end
        @(negedge wclk);
        push = 1'b0;
    endtask

    task automatic pop_items(input int count, input bit random_rate);
        int       taken;
        rf_data_t bits;
        taken = 0;
        while (taken < count) begin
            @(negedge rclk);
            bits = '1;
            if (random_rate) begin
                take_random_bits(1, bits);
            end
            pop       = bits[0];
            pop_taken = pop & ~empty;
            if (pop_taken) begin
                taken++;
            end
        end
        @(negedge rclk);
        pop       = 1'b0;
        pop_taken = 1'b0;
        // Empty follows in the cycle after the last accepted pop
        check_flag("empty", 1'b1, empty);
    endtask

    task automatic run_row(input row_t row);
        apply_reset(row.bypass);
        expect_idle_flags();
        probe_empty_pop();
        if (row.concurrent) begin
            fork
                push_items(row.pushes, 1'b1);
                pop_items(row.pops, 1'b1);
            join
        end else begin
            push_items(row.pushes, 1'b0);
            if (row.over_full) begin
                check_flag("full", 1'b1, full);
                overrun_pushes(OVERRUN_PUSHES);
            end
            pop_items(row.pops, 1'b0);
        end
    endtask

    // ------------------------------
    // Stimulus table and run
    // ------------------------------

    initial begin
        // pushes, pops, concurrent, pushes past full, reset bypass
        rows[0] = '{0,   0,   1'b0, 1'b0, 1'b0};
        rows[1] = '{64,  64,  1'b0, 1'b0, 1'b0};
        rows[2] = '{256, 256, 1'b0, 1'b1, 1'b0};
        rows[3] = '{600, 600, 1'b1, 1'b0, 1'b0};
        rows[4] = '{64,  64,  1'b0, 1'b0, 1'b1};

        for (int i = 0; i < ROW_COUNT; i++) begin
            cycle_limit += 2 * (rows[i].pushes + rows[i].pops) + 200;
        end

        for (int i = 0; i < ROW_COUNT; i++) begin
            run_row(rows[i]);
        end

        @(negedge wclk);
        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== files.f ====
rf_pkg.sv
reset_sync.sv
rf_array_2p.sv
rf_256x10.sv
fifo_wr_ctrl.sv
fifo_rd_ctrl.sv
cdc_fifo.sv
tb_cdc_fifo.sv

// ==== Makefile ====
SIM       := verilator
SIM_FLAGS := --binary --timing --assert
TOP       := tb_cdc_fifo
FILELIST  := files.f
BUILD_DIR := obj_dir

SOURCES   := $(shell grep -v '^+' $(FILELIST))
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM_BIN)
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
